// ==== src/alert_config.svh ====
// widths and counts for one alert class; ESC_PHASES must stay 4 to match the state and address enums
`ifndef ALERT_CONFIG_SVH
`define ALERT_CONFIG_SVH

//////////////////////////////
// alert inputs
//////////////////////////////

`define ALERT_NUM   8   // alert inputs, also mask width

//////////////////////////////
// datapath widths
//////////////////////////////

`define ACCU_CNT_DW 16  // accu, threshold, phase durations and write data
`define ESC_PHASES  4   // escalation phases = esc output width

// register port address width, enough for REG_CTRL..REG_MASK
`define REG_AW      3

`endif

// ==== src/alert_pkg.sv ====
// shared types; the write word is 16 bits and its ctrl view only defines the low three bits
`include "alert_config.svh"

package alert_pkg;

  // register map, one word per address
  typedef enum logic [`REG_AW-1:0] {
    REG_CTRL   = 3'd0,  // en, lock, clr
    REG_THRESH = 3'd1,  // accumulator threshold
    REG_PHASE0 = 3'd2,  // phase durations in cycles
    REG_PHASE1 = 3'd3,
    REG_PHASE2 = 3'd4,
    REG_PHASE3 = 3'd5,
    REG_MASK   = 3'd6   // alert enable mask
  } reg_addr_e;

  // control view of the write word
  typedef struct packed {
    logic [`ACCU_CNT_DW-4:0] rsvd;  // ignored on write
    logic                    clr;   // bit 2, clear request
    logic                    lock;  // bit 1, sticky until reset
    logic                    en;    // bit 0, class enable
  } reg_ctrl_t;

  // one write word, two decodings picked by the address
  typedef union packed {
    reg_ctrl_t               ctrl;   // REG_CTRL
    logic [`ACCU_CNT_DW-1:0] value;  // every other address
  } reg_word_u;

  // escalation FSM states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    PHASE0    = 3'd1,
    PHASE1    = 3'd2,
    PHASE2    = 3'd3,
    PHASE3    = 3'd4,
    TERMINAL  = 3'd5,  // all phases done, waits for clr
    FSM_ERROR = 3'd6   // counter mismatch, only reset leaves
  } esc_state_e;

endpackage

// ==== src/alert_class_regs.sv ====
// config regs: lock only clears on reset, back-to-back clr writes merge into a single clr pulse
`include "alert_config.svh"

module alert_class_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    we_i,                        // one cycle per write
  input  alert_pkg::reg_addr_e    addr_i,
  input  alert_pkg::reg_word_u    wdata_i,
  input  logic [`ALERT_NUM-1:0]   alert_i,                     // level alerts
  output logic                    class_en_o,
  output logic                    clr_o,                       // registered pulse
  output logic                    class_trig_o,                // comb, same cycle as alert_i
  output logic [`ACCU_CNT_DW-1:0] thresh_o,
  output logic [`ACCU_CNT_DW-1:0] phase_cyc_o [`ESC_PHASES]
);
  import alert_pkg::*;

  logic                    en_q;      // class enable
  logic                    lock_q;    // freezes config
  logic                    clr_q;     // clear pulse
  logic [`ACCU_CNT_DW-1:0] thresh_q;
  logic [`ACCU_CNT_DW-1:0] phase_q [`ESC_PHASES];
  logic [`ALERT_NUM-1:0]   mask_q;    // 1 = alert counts for this class
  logic                    ctrl_we;   // write hits REG_CTRL
  logic                    cfg_we;    // write hits a lockable reg

  //////////////////////////////
  // write decode
  //////////////////////////////

  assign ctrl_we = we_i && (addr_i == REG_CTRL);
  // everything but ctrl is frozen once lock is set
  assign cfg_we  = we_i && (addr_i != REG_CTRL) && !lock_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q     <= 1'b0;
      lock_q   <= 1'b0;
      clr_q    <= 1'b0;
      thresh_q <= '0;
      mask_q   <= '0;
      for (int k = 0; k < `ESC_PHASES; k++) begin
        phase_q[k] <= '0;
      end
    end else begin
      // clr is honoured even when locked, never two cycles in a row
      clr_q <= ctrl_we && wdata_i.ctrl.clr && !clr_q;
      if (ctrl_we) begin
        lock_q <= lock_q | wdata_i.ctrl.lock;    // set only, reset clears
        if (!lock_q) begin
          en_q <= wdata_i.ctrl.en;               // en frozen under lock
        end
      end
      if (cfg_we) begin
        case (addr_i)
          REG_THRESH: thresh_q   <= wdata_i.value;
          REG_PHASE0: phase_q[0] <= wdata_i.value;
          REG_PHASE1: phase_q[1] <= wdata_i.value;
          REG_PHASE2: phase_q[2] <= wdata_i.value;
          REG_PHASE3: phase_q[3] <= wdata_i.value;
          REG_MASK:   mask_q     <= wdata_i.value[`ALERT_NUM-1:0];  // upper bits dropped
          default: ;                                                 // unmapped, ignore
        endcase
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign class_en_o   = en_q;
  assign clr_o        = clr_q;
  assign thresh_o     = thresh_q;
  assign phase_cyc_o  = phase_q;
  assign class_trig_o = |(alert_i & mask_q);  // any masked-in alert

  // a clear request never stretches into a second cycle
  clr_single_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clr_o |=> !clr_o)
    else $error("clr pulse longer than one cycle");

endmodule

// ==== src/alert_cross_cnt.sv ====
// redundant saturating counter; err_o is comb and holds until clr_i or reset restores the pair
`include "alert_config.svh"

module alert_cross_cnt #(
  parameter int unsigned WIDTH = `ACCU_CNT_DW
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             clr_i,   // back to 0 / all-ones, wins over en_i
  input  logic             en_i,    // count request
  output logic [WIDTH-1:0] cnt_o,   // up counter value
  output logic             err_o    // pair out of step
);

  logic [WIDTH-1:0] up_q;   // starts at 0
  logic [WIDTH-1:0] dn_q;   // starts at all-ones
  logic [WIDTH-1:0] sum;    // all-ones while consistent
  logic             sat;    // up counter at max
  logic             step;

  assign sat  = &up_q;
  assign step = en_i && !sat;  // saturate, no wrap

  //////////////////////////////
  // counter pair
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (clr_i) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (step) begin
      up_q <= up_q + 1'b1;
      dn_q <= dn_q - 1'b1;
    end
  end

  // up + dn is constant while both step together
  assign sum   = up_q + dn_q;
  assign err_o = (sum != '1);
  assign cnt_o = up_q;

  // once saturated the count only moves on a clear
  sat_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (&cnt_o) && !clr_i |=> $stable(cnt_o))
    else $error("saturated count moved without clear");

endmodule

// ==== src/alert_accu.sv ====
// accumulator; the trigger compares the count before the increment, clear wins over a trigger
`include "alert_config.svh"

module alert_accu (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    class_en_i,
  input  logic                    clr_i,         // clear pulse from regs
  input  logic                    class_trig_i,  // masked alert OR
  input  logic [`ACCU_CNT_DW-1:0] thresh_i,
  output logic [`ACCU_CNT_DW-1:0] accu_cnt_o,
  output logic                    accu_trig_o,   // comb, starts escalation
  output logic                    accu_fail_o    // comb, counter pair mismatch
);

  logic trig_gated;  // trigger of an enabled class

  assign trig_gated = class_trig_i && class_en_i;

  // two counters in opposite directions guard the count
  alert_cross_cnt #(
    .WIDTH (`ACCU_CNT_DW)
  ) u_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clr_i   (clr_i),
    .en_i    (trig_gated),   // saturation handled inside
    .cnt_o   (accu_cnt_o),
    .err_o   (accu_fail_o)
  );

  // threshold reached on the old count, so the next trigger escalates
  assign accu_trig_o = trig_gated && (accu_cnt_o >= thresh_i);

  //////////////////////////////
  // assertions
  //////////////////////////////

  trig_needs_en_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accu_trig_o |-> class_en_i && class_trig_i)
    else $error("escalation trigger from a disabled class");

  // disabled class neither triggers nor counts
  dis_frozen_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !class_en_i && !clr_i |=> $stable(accu_cnt_o))
    else $error("count moved while class disabled");

endmodule

// ==== src/alert_esc_timer.sv ====
// escalation FSM; clr beats accu_trig in IDLE, a phase length of 0 runs as 1 cycle, FSM_ERROR is sticky
`include "alert_config.svh"

module alert_esc_timer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    accu_trig_i,   // start escalation, only seen in IDLE
  input  logic                    accu_fail_i,   // counter mismatch
  input  logic                    clr_i,         // abort / leave TERMINAL
  input  logic [`ACCU_CNT_DW-1:0] phase_cyc_i [`ESC_PHASES],
  output logic [`ESC_PHASES-1:0]  esc_o,
  output alert_pkg::esc_state_e   esc_state_o,
  output logic                    fault_o
);
  import alert_pkg::*;

  esc_state_e              state_q, state_d;
  logic [`ACCU_CNT_DW-1:0] timer_q, timer_d;  // cycles left in phase, minus one
  logic [1:0]              phase_idx;         // current phase, 0 outside phases

  // reload value, 0 and 1 both give a single cycle
  function automatic logic [`ACCU_CNT_DW-1:0] load_cnt(
    input logic [`ACCU_CNT_DW-1:0] cyc
  );
    return (cyc == '0) ? '0 : cyc - 1'b1;
  endfunction

  //////////////////////////////
  // phase decode
  //////////////////////////////

  always_comb begin
    case (state_q)
      PHASE1:  phase_idx = 2'd1;
      PHASE2:  phase_idx = 2'd2;
      PHASE3:  phase_idx = 2'd3;
      default: phase_idx = 2'd0;  // PHASE0 and non-phase states
    endcase
  end

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    timer_d = timer_q;
    case (state_q)
      IDLE: begin
        if (accu_trig_i && !clr_i) begin
          state_d = PHASE0;
          timer_d = load_cnt(phase_cyc_i[0]);  // sampled on entry
        end
      end
      PHASE0, PHASE1, PHASE2, PHASE3: begin
        if (clr_i) begin
          state_d = IDLE;                      // abort escalation
        end else if (timer_q != '0) begin
          timer_d = timer_q - 1'b1;
        end else if (phase_idx == 2'd3) begin
          state_d = TERMINAL;                  // last phase done
        end else begin
          state_d = esc_state_e'(state_q + 3'd1);
          timer_d = load_cnt(phase_cyc_i[phase_idx + 2'd1]);
        end
      end
      TERMINAL: begin
        if (clr_i) begin
          state_d = IDLE;
        end
      end
      FSM_ERROR: ;                   // stuck until reset
      default: state_d = FSM_ERROR;  // illegal encoding
    endcase
    // counter failure overrides everything
    if (accu_fail_i) begin
      state_d = FSM_ERROR;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      timer_q <= '0;
    end else begin
      state_q <= state_d;
      timer_q <= timer_d;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  always_comb begin
    esc_o = '0;
    case (state_q)
      PHASE0, PHASE1, PHASE2, PHASE3: esc_o[phase_idx] = 1'b1;  // one-hot phase
      FSM_ERROR:                      esc_o = '1;               // all actions on
      default: ;
    endcase
  end

  assign esc_state_o = state_q;
  assign fault_o     = (state_q == FSM_ERROR);

  // error state is terminal
  err_sticky_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q == FSM_ERROR |=> state_q == FSM_ERROR)
    else $error("left FSM_ERROR without reset");

  esc_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q != FSM_ERROR |-> $onehot0(esc_o))
    else $error("more than one escalation phase active");

endmodule

// ==== src/alert_class_top.sv ====
// one alert class with plain write strobes; no bus, ping, irq or receiver signalling
`include "alert_config.svh"

module alert_class_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    we_i,          // write strobe
  input  alert_pkg::reg_addr_e    addr_i,
  input  alert_pkg::reg_word_u    wdata_i,
  input  logic [`ALERT_NUM-1:0]   alert_i,
  output logic [`ACCU_CNT_DW-1:0] accu_cnt_o,
  output logic [`ESC_PHASES-1:0]  esc_o,
  output alert_pkg::esc_state_e   esc_state_o,
  output logic                    fault_o
);

  logic                    class_en;
  logic                    clr;         // one-cycle clear
  logic                    class_trig;
  logic [`ACCU_CNT_DW-1:0] thresh;
  logic [`ACCU_CNT_DW-1:0] phase_cyc [`ESC_PHASES];
  logic                    accu_trig;
  logic                    accu_fail;

  // config and alert masking
  alert_class_regs u_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .alert_i      (alert_i),
    .class_en_o   (class_en),
    .clr_o        (clr),
    .class_trig_o (class_trig),
    .thresh_o     (thresh),
    .phase_cyc_o  (phase_cyc)
  );

  // trigger counting
  alert_accu u_accu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .class_en_i   (class_en),
    .clr_i        (clr),
    .class_trig_i (class_trig),
    .thresh_i     (thresh),
    .accu_cnt_o   (accu_cnt_o),
    .accu_trig_o  (accu_trig),
    .accu_fail_o  (accu_fail)
  );

  // escalation sequence
  alert_esc_timer u_esc (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .accu_trig_i  (accu_trig),
    .accu_fail_i  (accu_fail),
    .clr_i        (clr),
    .phase_cyc_i  (phase_cyc),
    .esc_o        (esc_o),
    .esc_state_o  (esc_state_o),
    .fault_o      (fault_o)
  );

endmodule

// ==== verif/alert_class_tb.sv ====
// testbench for one alert class; fault-free runs only, the count climbs toward but never reaches 65535
`include "alert_config.svh"

module alert_class_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import alert_pkg::*;

  localparam int TEST_CYC = 3000;                // longest single test stretch
  localparam int MAX_CYC  = 4 * TEST_CYC + 500;  // all tests plus margin

  logic                    clk;
  logic                    rst_n;
  logic                    we;
  reg_addr_e               addr;
  reg_word_u               wdata;
  logic [`ALERT_NUM-1:0]   alert;
  logic [`ACCU_CNT_DW-1:0] accu_cnt;
  logic [`ESC_PHASES-1:0]  esc;
  esc_state_e              esc_state;
  logic                    fault;

  // reference model state
  logic                    m_en;
  logic                    m_lock;
  logic                    m_clr;                 // clear pulse in flight
  logic [`ACCU_CNT_DW-1:0] m_thresh;
  logic [`ACCU_CNT_DW-1:0] m_phase [`ESC_PHASES];
  logic [`ALERT_NUM-1:0]   m_mask;
  logic [`ACCU_CNT_DW-1:0] m_cnt;
  esc_state_e              m_state;
  int unsigned             m_left;                // cycles left in phase, current one included
  integer                  seed    = 32'ha3c0731e;
  int unsigned             cyc_cnt = 0;

  alert_class_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .we_i        (we),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .alert_i     (alert),
    .accu_cnt_o  (accu_cnt),
    .esc_o       (esc),
    .esc_state_o (esc_state),
    .fault_o     (fault)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // run limit
  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt > MAX_CYC) begin
      $display("timeout: simulation ran past %0d cycles without finishing", MAX_CYC);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic int unsigned rand_range(int unsigned lo, int unsigned hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic logic [`ALERT_NUM-1:0] pick_alert();
    return `ALERT_NUM'($random(seed));
  endfunction

  function automatic int unsigned phase_len(logic [`ACCU_CNT_DW-1:0] cyc);
    return (cyc == 0) ? 1 : cyc;  // zero still runs one cycle
  endfunction

  function automatic logic [`ESC_PHASES-1:0] exp_esc(esc_state_e st);
    case (st)
      PHASE0:    return 4'b0001;
      PHASE1:    return 4'b0010;
      PHASE2:    return 4'b0100;
      PHASE3:    return 4'b1000;
      FSM_ERROR: return '1;
      default:   return '0;
    endcase
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // one clock edge; every rule works on the values before the edge
  task automatic model_step();
    logic trig;
    logic atrig;
    logic ctrl_wr;
    logic old_lock;
    int   idx;
    trig     = |(alert & m_mask) && m_en;    // enabled class trigger
    atrig    = trig && (m_cnt >= m_thresh);  // old count vs threshold
    ctrl_wr  = we && (addr == REG_CTRL);
    old_lock = m_lock;
    idx      = int'(m_state) - int'(PHASE0);
    case (m_state)
      IDLE: begin
        if (atrig && !m_clr) begin
          m_state = PHASE0;
          m_left  = phase_len(m_phase[0]);
        end
      end
      PHASE0, PHASE1, PHASE2, PHASE3: begin
        if (m_clr) begin
          m_state = IDLE;                     // abort
        end else if (m_left > 1) begin
          m_left--;
        end else if (m_state == PHASE3) begin
          m_state = TERMINAL;
        end else begin
          m_state = esc_state_e'(int'(m_state) + 1);
          m_left  = phase_len(m_phase[idx + 1]);
        end
      end
      TERMINAL: begin
        if (m_clr) begin
          m_state = IDLE;
        end
      end
      default: ;
    endcase
    // clear beats an increment, count saturates
    if (m_clr) begin
      m_cnt = '0;
    end else if (trig && (m_cnt != '1)) begin
      m_cnt = m_cnt + 1'b1;
    end
    // en bit 0, lock bit 1, clr bit 2; back-to-back clr requests merge
    m_clr = ctrl_wr && wdata.value[2] && !m_clr;
    if (ctrl_wr) begin
      if (!old_lock) begin
        m_en = wdata.value[0];
      end
      m_lock = old_lock | wdata.value[1];
    end
    if (we && (addr != REG_CTRL) && !old_lock) begin
      case (addr)
        REG_THRESH: m_thresh = wdata.value;
        REG_PHASE0, REG_PHASE1, REG_PHASE2, REG_PHASE3:
          m_phase[int'(addr) - int'(REG_PHASE0)] = wdata.value;
        REG_MASK:   m_mask = wdata.value[`ALERT_NUM-1:0];
        default: ;
      endcase
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic do_reset();
    rst_n = 1'b0;
    we    = 1'b0;
    addr  = REG_CTRL;
    wdata = '0;
    alert = '0;
    repeat (5) @(posedge clk);
    #10;
    rst_n    = 1'b1;
    m_en     = 1'b0;
    m_lock   = 1'b0;
    m_clr    = 1'b0;
    m_thresh = '0;
    m_mask   = '0;
    m_cnt    = '0;
    m_state  = IDLE;
    m_left   = 0;
    for (int k = 0; k < `ESC_PHASES; k++) begin
      m_phase[k] = '0;
    end
  endtask

  // called 10 ns after a rising edge, returns 10 ns after the next one
  task automatic drive_cycle(input logic we_v, input reg_addr_e addr_v,
                             input logic [`ACCU_CNT_DW-1:0] data_v,
                             input logic [`ALERT_NUM-1:0] alert_v);
    we          = we_v;
    addr        = addr_v;
    wdata.value = data_v;
    alert       = alert_v;
    @(negedge clk);                                   // outputs settled
    check_eq(accu_cnt, m_cnt, "accu count");
    check_eq(esc_state, m_state, "esc state");
    check_eq(esc, exp_esc(m_state), "esc output");
    check_eq(fault, 1'b0, "fault");
    @(posedge clk);
    model_step();
    #10;
  endtask

  task automatic idle_cycle(input logic [`ALERT_NUM-1:0] alert_v);
    drive_cycle(1'b0, REG_CTRL, '0, alert_v);
  endtask

  task automatic write_reg(input reg_addr_e a, input logic [`ACCU_CNT_DW-1:0] d,
                           input logic [`ALERT_NUM-1:0] alert_v);
    drive_cycle(1'b1, a, d, alert_v);
  endtask

  task automatic write_ctrl(input logic en_v, input logic lock_v, input logic clr_v,
                            input logic [`ALERT_NUM-1:0] alert_v);
    reg_word_u w;
    w           = '0;
    w.ctrl.en   = en_v;
    w.ctrl.lock = lock_v;
    w.ctrl.clr  = clr_v;
    drive_cycle(1'b1, REG_CTRL, w.value, alert_v);
  endtask

  task automatic random_config();
    write_reg(REG_THRESH, rand_range(2, 20), '0);
    for (int k = 0; k < `ESC_PHASES; k++) begin
      write_reg(reg_addr_e'(int'(REG_PHASE0) + k), rand_range(0, 6), '0);
    end
    write_reg(REG_MASK, rand_range(1, 255), '0);
  endtask

  // count is zero and FSM idle two edges after the write
  task automatic clear_check();
    write_ctrl(1'b1, 1'b0, 1'b1, pick_alert());
    idle_cycle(pick_alert());
    check_eq(accu_cnt, '0, "count two cycles after clr");
    check_eq(esc_state, IDLE, "state after clr");
  endtask

  initial begin
    logic [`ACCU_CNT_DW-1:0] frozen;
    int unsigned             burst;
    logic                    burst_on;
    int unsigned             pick;
    do_reset();

    // config, enable, mask and disable
    random_config();
    write_ctrl(1'b1, 1'b0, 1'b0, '0);
    repeat (600) idle_cycle(pick_alert());
    frozen = m_cnt;
    repeat (50) idle_cycle(~m_mask);                 // masked-out alerts only
    check_eq(accu_cnt, frozen, "count with masked-out alerts");
    write_ctrl(1'b0, 1'b0, 1'b0, '0);
    frozen = m_cnt;
    repeat (300) idle_cycle(pick_alert());
    check_eq(accu_cnt, frozen, "count while disabled");

    // alert bursts into escalation, phase 0 forced to zero length
    random_config();
    write_reg(REG_PHASE0, '0, '0);
    write_ctrl(1'b1, 1'b0, 1'b1, '0);
    burst    = 0;
    burst_on = 1'b0;
    for (int c = 0; c < TEST_CYC; c++) begin
      if (burst == 0) begin
        burst_on = rand_range(0, 1);
        burst    = rand_range(1, 12);
      end
      burst--;
      if ((m_state == TERMINAL) && (rand_range(0, 3) == 0) && !m_clr) begin
        write_ctrl(1'b1, 1'b0, 1'b1, '0);           // restart
      end else begin
        idle_cycle(burst_on ? pick_alert() : '0);
      end
    end

    // random clears over counting and escalation
    for (int c = 0; c < 1500; c++) begin
      if ((rand_range(0, 19) == 0) && !m_clr) begin
        clear_check();
      end else begin
        idle_cycle(pick_alert());
      end
    end

    // lock, then try to change config
    write_ctrl(1'b1, 1'b1, 1'b0, '0);
    for (int c = 0; c < 1500; c++) begin
      pick = rand_range(0, 15);
      if (pick == 0) begin
        write_reg(reg_addr_e'(rand_range(1, 6)), rand_range(0, 16'hffff), pick_alert());
      end else if (pick == 1) begin
        write_ctrl(1'b0, rand_range(0, 1), 1'b0, pick_alert());  // drop en attempt
      end else if ((pick == 2) && !m_clr) begin
        clear_check();
      end else begin
        idle_cycle(pick_alert());
      end
    end

    // long run toward saturation, lock gone after reset
    do_reset();
    write_reg(REG_THRESH, 16'hffff, '0);
    for (int k = 0; k < `ESC_PHASES; k++) begin
      write_reg(reg_addr_e'(int'(REG_PHASE0) + k), 16'd1, '0);
    end
    write_reg(REG_MASK, 16'h00ff, '0);
    write_ctrl(1'b1, 1'b0, 1'b0, '0);
    for (int c = 0; c < TEST_CYC; c++) begin
      idle_cycle(pick_alert() | 8'h01);             // one alert always high
    end
    check_eq(esc_state, IDLE, "state below max threshold");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/alert_pkg.sv
src/alert_class_regs.sv
src/alert_cross_cnt.sv
src/alert_accu.sv
src/alert_esc_timer.sv
src/alert_class_top.sv
verif/alert_class_tb.sv
